/* source/tdc_pkg.sv */
package tdc_pkg;

  //////////////////////////////////////////////////////////////////////
  // board constants
  //////////////////////////////////////////////////////////////////////

  // trigger sections A, B and C, section A in the low channel bits
  localparam int NUM_SECTIONS = 3;

  // scaler counters and readout data
  localparam int COUNT_WIDTH = 32;

  //////////////////////////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////////////////////////

  // trigger output setup, shared by both output groups
  typedef struct packed {
    // section enables for trigger output 0, bit 0 is section A
    logic [NUM_SECTIONS-1:0] group_0;
    // section enables for trigger output 1
    logic [NUM_SECTIONS-1:0] group_1;
    // pulse high for hightime+1 cycles
    logic [3:0]              hightime;
    // then ignore the input for deadtime+1 cycles
    logic [3:0]              deadtime;
  } trigger_cfg_t;

  // scaler setup
  typedef struct packed {
    // freeze all counters while busy is high
    logic stop_counting_on_busy;
    // ignore the external latch input
    logic disable_external_latch;
  } scaler_cfg_t;

  //////////////////////////////////////////////////////////////////////
  // state encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SHAPER_IDLE = 2'd0,
    SHAPER_HIGH = 2'd1,
    SHAPER_DEAD = 2'd2
  } shaper_state_e;

endpackage

/* source/trigger_or_tree.sv */
`timescale 1ns/1ps

module trigger_or_tree #(
  parameter int SECTION_CHANNELS = 8
) (
  input  logic                                             CLK2X,
  input  logic                                             tdc_reset_start,
  input  logic [tdc_pkg::NUM_SECTIONS*SECTION_CHANNELS-1:0] i_hits,
  input  tdc_pkg::trigger_cfg_t                            i_trigger_cfg,
  output logic [1:0]                                       o_group_trigger
);

  localparam int NUM_CHANNELS      = tdc_pkg::NUM_SECTIONS * SECTION_CHANNELS;
  localparam int NUM_QUADS         = NUM_CHANNELS / 4;
  localparam int QUADS_PER_SECTION = SECTION_CHANNELS / 4;

  logic [NUM_QUADS-1:0]             quad_or;
  logic [NUM_QUADS-1:0]             quad_or_q;
  logic [tdc_pkg::NUM_SECTIONS-1:0] section_or;
  logic [tdc_pkg::NUM_SECTIONS-1:0] section_or_q;
  logic [tdc_pkg::NUM_SECTIONS-1:0] group_0_q;
  logic [tdc_pkg::NUM_SECTIONS-1:0] group_1_q;
  logic [1:0]                       group_or_q;

  //////////////////////////////////////////////////////////////////////
  // leaf and section reductions
  //////////////////////////////////////////////////////////////////////

  // four channels per leaf
  always_comb begin
    for (int q = 0; q < NUM_QUADS; q++) begin
      quad_or[q] = |i_hits[4*q +: 4];
    end
  end

  always_comb begin
    for (int s = 0; s < tdc_pkg::NUM_SECTIONS; s++) begin
      section_or[s] = |quad_or_q[s*QUADS_PER_SECTION +: QUADS_PER_SECTION];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // four register stages, hit to group output in 4 cycles
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2X) begin
    if (tdc_reset_start) begin
      quad_or_q    <= '0;
      section_or_q <= '0;
      group_0_q    <= '0;
      group_1_q    <= '0;
      group_or_q   <= '0;
    end else begin
      quad_or_q    <= quad_or;
      section_or_q <= section_or;
      // only enabled sections reach a group
      group_0_q    <= section_or_q & i_trigger_cfg.group_0;
      group_1_q    <= section_or_q & i_trigger_cfg.group_1;
      group_or_q   <= {|group_1_q, |group_0_q};
    end
  end

  assign o_group_trigger = group_or_q;

endmodule

/* source/output_shaper.sv */
`timescale 1ns/1ps

module output_shaper (
  input  logic                  CLK2X,
  input  logic                  tdc_reset_start,
  input  logic                  i_level,
  input  tdc_pkg::trigger_cfg_t i_trigger_cfg,
  output logic                  o_pulse
);

  tdc_pkg::shaper_state_e state;
  logic [3:0]             count_q;

  //////////////////////////////////////////////////////////////////////
  // pulse FSM
  //////////////////////////////////////////////////////////////////////

  // count_q holds the cycles left in the current phase minus one
  always_ff @(posedge CLK2X) begin
    if (tdc_reset_start) begin
      state   <= tdc_pkg::SHAPER_IDLE;
      count_q <= '0;
    end else begin
      case (state)
        tdc_pkg::SHAPER_IDLE: begin
          if (i_level) begin
            state   <= tdc_pkg::SHAPER_HIGH;
            count_q <= i_trigger_cfg.hightime;
          end
        end
        tdc_pkg::SHAPER_HIGH: begin
          if (count_q == '0) begin
            state   <= tdc_pkg::SHAPER_DEAD;
            count_q <= i_trigger_cfg.deadtime;
          end else begin
            count_q <= count_q - 4'd1;
          end
        end
        tdc_pkg::SHAPER_DEAD: begin
          // input is ignored until the dead time runs out
          if (count_q == '0) begin
            state <= tdc_pkg::SHAPER_IDLE;
          end else begin
            count_q <= count_q - 4'd1;
          end
        end
        default: begin
          state   <= tdc_pkg::SHAPER_IDLE;
          count_q <= '0;
        end
      endcase
    end
  end

  assign o_pulse = (state == tdc_pkg::SHAPER_HIGH);

endmodule

/* source/scaler_bank.sv */
`timescale 1ns/1ps

module scaler_bank #(
  parameter int SECTION_CHANNELS = 8
) (
  input  logic                                   CLK2X,
  input  logic                                   tdc_reset_start,
  input  logic [tdc_pkg::NUM_SECTIONS*SECTION_CHANNELS-1:0] i_hits,
  input  logic                                   i_busy,
  input  logic                                   i_ext_latch,
  input  logic                                   i_bus_latch,
  input  logic                                   i_counter_reset,
  input  tdc_pkg::scaler_cfg_t                   i_scaler_cfg,
  output logic [tdc_pkg::COUNT_WIDTH-1:0]        o_latched_clock,
  output logic [tdc_pkg::NUM_SECTIONS*SECTION_CHANNELS*tdc_pkg::COUNT_WIDTH-1:0]
                                                 o_latched_counts
);

  localparam int NUM_CHANNELS = tdc_pkg::NUM_SECTIONS * SECTION_CHANNELS;
  localparam int CW           = tdc_pkg::COUNT_WIDTH;

  logic                               inhibit;
  logic [NUM_CHANNELS-1:0]            hit_q;
  logic                               clock_en_q;
  logic                               ext_latch_q;
  logic                               ext_latch_rise;
  logic                               latch_strobe;
  logic [CW-1:0]                      clock_count_q;
  logic [CW-1:0]                      latched_clock_q;
  logic [NUM_CHANNELS-1:0][CW-1:0]    counts_q;
  logic [NUM_CHANNELS-1:0][CW-1:0]    latched_counts_q;

  //////////////////////////////////////////////////////////////////////
  // busy gating
  //////////////////////////////////////////////////////////////////////

  assign inhibit = i_busy & i_scaler_cfg.stop_counting_on_busy;

  // hits and the clock enable share one stage so the counts stay aligned
  always_ff @(posedge CLK2X) begin
    if (tdc_reset_start) begin
      hit_q      <= '0;
      clock_en_q <= 1'b0;
    end else begin
      hit_q      <= i_hits & {NUM_CHANNELS{~inhibit}};
      clock_en_q <= ~inhibit;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // channel counters and reference clock counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2X) begin
    if (tdc_reset_start || i_counter_reset) begin
      counts_q      <= '0;
      clock_count_q <= '0;
    end else begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        counts_q[ch] <= counts_q[ch] + {{(CW-1){1'b0}}, hit_q[ch]};
      end
      clock_count_q <= clock_count_q + {{(CW-1){1'b0}}, clock_en_q};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // latch strobe and latched copies
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2X) begin
    if (tdc_reset_start) begin
      ext_latch_q <= 1'b0;
    end else begin
      ext_latch_q <= i_ext_latch;
    end
  end

  // external input only counts on its rising edge
  assign ext_latch_rise = i_ext_latch & ~ext_latch_q;
  assign latch_strobe   = i_bus_latch |
                          (ext_latch_rise & ~i_scaler_cfg.disable_external_latch);

  // snapshot of the counts as they stand at the strobe edge
  always_ff @(posedge CLK2X) begin
    if (tdc_reset_start) begin
      latched_counts_q <= '0;
      latched_clock_q  <= '0;
    end else if (latch_strobe) begin
      latched_counts_q <= counts_q;
      latched_clock_q  <= clock_count_q;
    end
  end

  assign o_latched_clock  = latched_clock_q;
  assign o_latched_counts = latched_counts_q;

endmodule

/* source/scaler_readout.sv */
`timescale 1ns/1ps

module scaler_readout #(
  parameter int SECTION_CHANNELS = 8
) (
  input  logic                            CLK2X,
  input  logic                            tdc_reset_start,
  input  logic                            i_read_clock,
  input  logic                            i_read_next,
  input  logic [tdc_pkg::COUNT_WIDTH-1:0] i_latched_clock,
  input  logic [tdc_pkg::NUM_SECTIONS*SECTION_CHANNELS*tdc_pkg::COUNT_WIDTH-1:0]
                                          i_latched_counts,
  output logic [tdc_pkg::COUNT_WIDTH-1:0] o_read_data,
  output logic                            o_read_valid
);

  localparam int NUM_CHANNELS = tdc_pkg::NUM_SECTIONS * SECTION_CHANNELS;
  localparam int CW           = tdc_pkg::COUNT_WIDTH;
  localparam int PTR_WIDTH    = $clog2(NUM_CHANNELS);
  localparam logic [PTR_WIDTH-1:0] LAST_CHANNEL = PTR_WIDTH'(NUM_CHANNELS - 1);

  logic [NUM_CHANNELS-1:0][CW-1:0] counts;
  logic [PTR_WIDTH-1:0]            read_ptr_q;
  logic [CW-1:0]                   read_data_q;
  logic                            read_valid_q;

  // per-channel view of the flat latched vector
  assign counts = i_latched_counts;

  //////////////////////////////////////////////////////////////////////
  // read pointer and data register
  //////////////////////////////////////////////////////////////////////

  // a clock read rewinds, a channel read returns the pointed count and
  // steps on, holding at the last channel
  always_ff @(posedge CLK2X) begin
    if (tdc_reset_start) begin
      read_ptr_q   <= '0;
      read_data_q  <= '0;
      read_valid_q <= 1'b0;
    end else begin
      read_valid_q <= i_read_clock | i_read_next;
      if (i_read_clock) begin
        read_data_q <= i_latched_clock;
        read_ptr_q  <= '0;
      end else if (i_read_next) begin
        read_data_q <= counts[read_ptr_q];
        if (read_ptr_q != LAST_CHANNEL) begin
          read_ptr_q <= read_ptr_q + PTR_WIDTH'(1);
        end
      end
    end
  end

  assign o_read_data  = read_data_q;
  assign o_read_valid = read_valid_q;

endmodule

/* source/trigger_scaler_top.sv */
`timescale 1ns/1ps

module trigger_scaler_top #(
  parameter int SECTION_CHANNELS = 8
) (
  input  logic                                             CLK2X,
  input  logic                                             tdc_reset_start,
  input  logic [tdc_pkg::NUM_SECTIONS*SECTION_CHANNELS-1:0] i_hits,
  input  tdc_pkg::trigger_cfg_t                            i_trigger_cfg,
  input  tdc_pkg::scaler_cfg_t                             i_scaler_cfg,
  input  logic                                             i_busy,
  input  logic                                             i_ext_latch,
  input  logic                                             i_counter_reset,
  input  logic                                             i_bus_latch,
  input  logic                                             i_read_clock,
  input  logic                                             i_read_next,
  output logic [1:0]                                       o_trigger,
  output logic [tdc_pkg::COUNT_WIDTH-1:0]                  o_read_data,
  output logic                                             o_read_valid
);

  localparam int NUM_CHANNELS = tdc_pkg::NUM_SECTIONS * SECTION_CHANNELS;

  logic [1:0]                                       group_trigger;
  logic [tdc_pkg::COUNT_WIDTH-1:0]                  latched_clock;
  logic [NUM_CHANNELS*tdc_pkg::COUNT_WIDTH-1:0]     latched_counts;

  //////////////////////////////////////////////////////////////////////
  // trigger path
  //////////////////////////////////////////////////////////////////////

  trigger_or_tree #(
    .SECTION_CHANNELS (SECTION_CHANNELS)
  ) u_or_tree (
    .CLK2X           (CLK2X),
    .tdc_reset_start (tdc_reset_start),
    .i_hits          (i_hits),
    .i_trigger_cfg   (i_trigger_cfg),
    .o_group_trigger (group_trigger)
  );

  // one shaper per trigger group
  output_shaper u_shaper_0 (
    .CLK2X           (CLK2X),
    .tdc_reset_start (tdc_reset_start),
    .i_level         (group_trigger[0]),
    .i_trigger_cfg   (i_trigger_cfg),
    .o_pulse         (o_trigger[0])
  );

  output_shaper u_shaper_1 (
    .CLK2X           (CLK2X),
    .tdc_reset_start (tdc_reset_start),
    .i_level         (group_trigger[1]),
    .i_trigger_cfg   (i_trigger_cfg),
    .o_pulse         (o_trigger[1])
  );

  //////////////////////////////////////////////////////////////////////
  // scaler path
  //////////////////////////////////////////////////////////////////////

  scaler_bank #(
    .SECTION_CHANNELS (SECTION_CHANNELS)
  ) u_scaler_bank (
    .CLK2X            (CLK2X),
    .tdc_reset_start  (tdc_reset_start),
    .i_hits           (i_hits),
    .i_busy           (i_busy),
    .i_ext_latch      (i_ext_latch),
    .i_bus_latch      (i_bus_latch),
    .i_counter_reset  (i_counter_reset),
    .i_scaler_cfg     (i_scaler_cfg),
    .o_latched_clock  (latched_clock),
    .o_latched_counts (latched_counts)
  );

  scaler_readout #(
    .SECTION_CHANNELS (SECTION_CHANNELS)
  ) u_scaler_readout (
    .CLK2X            (CLK2X),
    .tdc_reset_start  (tdc_reset_start),
    .i_read_clock     (i_read_clock),
    .i_read_next      (i_read_next),
    .i_latched_clock  (latched_clock),
    .i_latched_counts (latched_counts),
    .o_read_data      (o_read_data),
    .o_read_valid     (o_read_valid)
  );

endmodule

/* dv/trigger_scaler_properties.sv */
`timescale 1ns/1ps

module trigger_scaler_properties #(
  parameter int SECTION_CHANNELS = 8
) (
  input logic                                             CLK2X,
  input logic                                             tdc_reset_start,
  input logic [tdc_pkg::NUM_SECTIONS*SECTION_CHANNELS-1:0] i_hits,
  input tdc_pkg::trigger_cfg_t                            i_trigger_cfg,
  input tdc_pkg::shaper_state_e                           i_shaper_0_state,
  input tdc_pkg::shaper_state_e                           i_shaper_1_state,
  input logic                                             i_read_clock,
  input logic                                             i_read_next,
  input logic [1:0]                                       i_trigger,
  input logic                                             i_read_valid
);

  logic [tdc_pkg::NUM_SECTIONS-1:0] section_hit;
  logic [1:0]                       group_hit;
  logic [1:0]                       shaper_idle;
  int                               valid_fails = 0;
  int                               fail_count;

  always_comb begin
    for (int s = 0; s < tdc_pkg::NUM_SECTIONS; s++) begin
      section_hit[s] = |i_hits[s*SECTION_CHANNELS +: SECTION_CHANNELS];
    end
  end

  assign group_hit   = {|(section_hit & i_trigger_cfg.group_1),
                        |(section_hit & i_trigger_cfg.group_0)};
  assign shaper_idle = {i_shaper_1_state == tdc_pkg::SHAPER_IDLE,
                        i_shaper_0_state == tdc_pkg::SHAPER_IDLE};

  //////////////////////////////////////////////////////////////////////
  // trigger outputs, one block per group
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < 2; g++) begin : gen_group
    // consecutive high and low cycles seen on the output
    logic [7:0] high_run;
    logic [7:0] low_run;
    int         fails = 0;

    always_ff @(posedge CLK2X) begin
      if (tdc_reset_start) begin
        high_run <= '0;
        low_run  <= 8'hff;
      end else if (i_trigger[g]) begin
        high_run <= high_run + 8'd1;
        low_run  <= '0;
      end else begin
        high_run <= '0;
        if (low_run != 8'hff) begin
          low_run <= low_run + 8'd1;
        end
      end
    end

    a_rise_needs_hit: assert property (@(posedge CLK2X) disable iff (tdc_reset_start)
      $rose(i_trigger[g]) |-> $past(group_hit[g], 5))
      else begin
        $error("trigger %0d rose without a group hit 5 cycles earlier", g);
        fails++;
      end

    // idle shaper with a hit 5 cycles back must fire now
    a_hit_to_pulse: assert property (@(posedge CLK2X) disable iff (tdc_reset_start)
      $past(group_hit[g], 5) && $past(shaper_idle[g]) |-> i_trigger[g])
      else begin
        $error("trigger %0d missed a hit on an idle shaper", g);
        fails++;
      end

    a_high_time: assert property (@(posedge CLK2X) disable iff (tdc_reset_start)
      $fell(i_trigger[g]) |-> high_run == 8'(i_trigger_cfg.hightime) + 8'd1)
      else begin
        $error("trigger %0d pulse was %0d cycles long", g, high_run);
        fails++;
      end

    a_dead_time: assert property (@(posedge CLK2X) disable iff (tdc_reset_start)
      $rose(i_trigger[g]) |-> low_run > 8'(i_trigger_cfg.deadtime))
      else begin
        $error("trigger %0d fired after only %0d low cycles", g, low_run);
        fails++;
      end
  end

  // read data follows each strobe by exactly one cycle
  a_read_valid: assert property (@(posedge CLK2X) disable iff (tdc_reset_start)
    i_read_valid == $past(i_read_clock || i_read_next))
    else begin
      $error("read valid does not follow the read strobe by one cycle");
      valid_fails++;
    end

  assign fail_count = gen_group[0].fails + gen_group[1].fails + valid_fails;

endmodule

bind trigger_scaler_top trigger_scaler_properties #(
  .SECTION_CHANNELS (SECTION_CHANNELS)
) u_props (
  .CLK2X            (CLK2X),
  .tdc_reset_start  (tdc_reset_start),
  .i_hits           (i_hits),
  .i_trigger_cfg    (i_trigger_cfg),
  .i_shaper_0_state (u_shaper_0.state),
  .i_shaper_1_state (u_shaper_1.state),
  .i_read_clock     (i_read_clock),
  .i_read_next      (i_read_next),
  .i_trigger        (o_trigger),
  .i_read_valid     (o_read_valid)
);

/* dv/tb_trigger_scaler.sv */
`timescale 1ns/1ps

module tb_trigger_scaler;

  localparam int SECTION_CHANNELS = 8;
  localparam int NUM_CH           = tdc_pkg::NUM_SECTIONS * SECTION_CHANNELS;
  localparam int CW               = tdc_pkg::COUNT_WIDTH;
  localparam int MAX_CYCLES       = 4000;

  logic                  CLK2X;
  logic                  tdc_reset_start;
  logic [NUM_CH-1:0]     hits;
  tdc_pkg::trigger_cfg_t trigger_cfg;
  tdc_pkg::scaler_cfg_t  scaler_cfg;
  logic                  busy;
  logic                  ext_latch;
  logic                  counter_reset;
  logic                  bus_latch;
  logic                  read_clock;
  logic                  read_next;
  logic [1:0]            trigger;
  logic [CW-1:0]         read_data;
  logic                  read_valid;

  // expected scaler state, built from the timing rules
  logic [CW-1:0]     exp_clock;
  logic [CW-1:0]     lat_clock;
  logic [CW-1:0]     exp_counts [NUM_CH];
  logic [CW-1:0]     lat_counts [NUM_CH];
  logic [NUM_CH-1:0] pend_hits;
  logic              pend_clock;
  logic              prev_ext;
  int                read_ptr;
  logic [CW-1:0]     exp_reads [$];
  logic [NUM_CH-1:0] one_hit;
  logic [31:0]       rnd;
  integer            seed;
  int                errors = 0;
  int                cycles = 0;

  trigger_scaler_top #(
    .SECTION_CHANNELS (SECTION_CHANNELS)
  ) dut (
    .CLK2X           (CLK2X),
    .tdc_reset_start (tdc_reset_start),
    .i_hits          (hits),
    .i_trigger_cfg   (trigger_cfg),
    .i_scaler_cfg    (scaler_cfg),
    .i_busy          (busy),
    .i_ext_latch     (ext_latch),
    .i_counter_reset (counter_reset),
    .i_bus_latch     (bus_latch),
    .i_read_clock    (read_clock),
    .i_read_next     (read_next),
    .o_trigger       (trigger),
    .o_read_data     (read_data),
    .o_read_valid    (read_valid)
  );

  initial begin
    CLK2X = 1'b0;
    forever #20 CLK2X = ~CLK2X;
  end

  always @(posedge CLK2X) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // each valid read is matched against the oldest outstanding strobe
  always @(posedge CLK2X) begin
    if (read_valid) begin
      if (exp_reads.size() == 0) begin
        errors++;
        $display("ERR %0t: read valid without an outstanding read", $time);
      end else begin
        a_read_data: assert (read_data == exp_reads[0]) else begin
          errors++;
          $display("ERR %0t: read data %0d, expected %0d", $time, read_data, exp_reads[0]);
        end
        void'(exp_reads.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus, one call per clock cycle, entered at a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic tick(input logic [NUM_CH-1:0] h, input logic b, input logic ext,
                      input logic cr, input logic bl, input logic rc, input logic rn);
    logic inhibit;
    logic latch;
    hits          = h;
    busy          = b;
    ext_latch     = ext;
    counter_reset = cr;
    bus_latch     = bl;
    read_clock    = rc;
    read_next     = rn;
    inhibit = b & scaler_cfg.stop_counting_on_busy;
    latch   = bl | (ext & ~prev_ext & ~scaler_cfg.disable_external_latch);
    prev_ext = ext;
    // reads see the latched set from before this edge
    if (rc) begin
      exp_reads.push_back(lat_clock);
      read_ptr = 0;
    end else if (rn) begin
      exp_reads.push_back(lat_counts[read_ptr]);
      if (read_ptr < NUM_CH - 1) begin
        read_ptr++;
      end
    end
    if (latch) begin
      lat_clock  = exp_clock;
      lat_counts = exp_counts;
    end
    // what is sampled at this edge shows up in the counts one edge later
    if (cr) begin
      exp_clock = '0;
      for (int i = 0; i < NUM_CH; i++) begin
        exp_counts[i] = '0;
      end
    end else begin
      if (pend_clock) begin
        exp_clock++;
      end
      for (int i = 0; i < NUM_CH; i++) begin
        if (pend_hits[i]) begin
          exp_counts[i]++;
        end
      end
    end
    pend_clock = ~inhibit;
    pend_hits  = inhibit ? '0 : h;
    @(negedge CLK2X);
  endtask

  task automatic idle(input int n);
    repeat (n) tick('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // clock read, then n channel reads back to back
  task automatic read_scalers(input int n);
    tick('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    repeat (n) tick('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    idle(2);
  endtask

  // counter reset, n cycles of a pattern, then a bus latch
  task automatic count_pattern(input logic [NUM_CH-1:0] h, input logic b, input int n);
    tick('0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    repeat (n) tick(h, b, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(2);
    tick('0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
  endtask

  initial begin
    seed            = 32'hef5f_2fe9;
    tdc_reset_start = 1'b1;
    hits            = '0;
    busy            = 1'b0;
    ext_latch       = 1'b0;
    counter_reset   = 1'b0;
    bus_latch       = 1'b0;
    read_clock      = 1'b0;
    read_next       = 1'b0;
    trigger_cfg = '{group_0: 3'b010, group_1: 3'b001, hightime: 4'd3, deadtime: 4'd5};
    scaler_cfg  = '{stop_counting_on_busy: 1'b1, disable_external_latch: 1'b0};
    exp_clock  = '0;
    lat_clock  = '0;
    pend_hits  = '0;
    pend_clock = 1'b0;
    prev_ext   = 1'b0;
    read_ptr   = 0;
    for (int i = 0; i < NUM_CH; i++) begin
      exp_counts[i] = '0;
      lat_counts[i] = '0;
    end
    // reset spans four rising edges, released on the following falling edge
    repeat (4) @(posedge CLK2X);
    @(negedge CLK2X);
    tdc_reset_start = 1'b0;
    a_reset_state: assert (trigger == 2'b00 && !read_valid && read_data == '0) else begin
      errors++;
      $display("ERR %0t: outputs not cleared by reset", $time);
    end

    // pointer starts at channel 0 after reset
    tick('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    idle(3);

    // single hit in section B, then a long hit for repeated pulses
    one_hit     = '0;
    one_hit[10] = 1'b1;
    tick(one_hit, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(20);
    repeat (40) tick(one_hit, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(20);

    // random hits, then read every channel and past the last one
    tick('0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    repeat (50) begin
      rnd = $random(seed);
      tick(rnd[NUM_CH-1:0], 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    idle(2);
    tick('0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    read_scalers(NUM_CH + 3);

    // busy freezes the counters only while the busy stop is set
    count_pattern('1, 1'b1, 10);
    read_scalers(3);
    scaler_cfg.stop_counting_on_busy = 1'b0;
    count_pattern('1, 1'b1, 10);
    read_scalers(3);

    // external latch edge, honored and then ignored
    count_pattern('1, 1'b0, 5);
    repeat (5) tick('1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(2);
    repeat (2) tick('0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(2);
    read_scalers(2);
    scaler_cfg.disable_external_latch = 1'b1;
    repeat (5) tick('1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(2);
    repeat (2) tick('0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    idle(2);
    read_scalers(2);
    idle(5);

    if (exp_reads.size() != 0) begin
      errors++;
      $display("%0d read strobes never produced read data", exp_reads.size());
    end
    $display("errors: testbench %0d, assertions %0d", errors, dut.u_props.fail_count);
    if (errors + dut.u_props.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* build.f */
source/tdc_pkg.sv
source/trigger_or_tree.sv
source/output_shaper.sv
source/scaler_bank.sv
source/scaler_readout.sv
source/trigger_scaler_top.sv
dv/trigger_scaler_properties.sv
dv/tb_trigger_scaler.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_trigger_scaler -f build.f -o tb_sim

out=$(./obj_dir/tb_sim +verilator+error+limit+1000 2>&1) || true
echo "$out"
echo "$out" | grep -qx "PASS: all tests"
